// ==== mb_writer.f ====
+incdir+include
source/mb_axi_pkg.sv
source/mb_ctrl_pkg.sv
source/mb_frame_ctrl.sv
source/mb_stage_fifo.sv
source/mb_aw_gen.sv
source/mb_wdata_chan.sv
source/mb_bresp_track.sv
source/mb_writer.sv
tests/mb_writer_chk.sv
tests/mb_writer_tb.sv

// ==== Makefile ====
# Verilator build and run for the macroblock writer
TOP = mb_writer_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mb_writer.f -o sim_top
	./obj_dir/sim_top 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/mb_writer_tb.sv ====
/* Testbench for mb_writer with a random encoder and AXI slave. Frames
   run one at a time, and only the third frame gets an SLVERR. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_writer_tb;
    import mb_axi_pkg::*;
    import mb_ctrl_pkg::*;

    localparam int BYTES = `MB_DATA_W / 8;
    // Staging FIFO depth in the top level
    localparam int FIFO_DEPTH = 16;
    // 19 macroblocks, one slot for the zero frame, plus reset
    localparam int LIMIT = 200 * 20 + 16;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    frame_cmd_t            cmd;
    logic                  enc_push;
    logic [`MB_DATA_W-1:0] enc_data;
    logic                  enc_full;
    logic                  busy;
    logic                  done;
    logic                  resp_err;
    axi_aw_t               aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_w_t                w;
    logic                  w_valid;
    logic                  w_ready;
    axi_resp_e             b_resp;
    logic                  b_valid;
    logic                  b_ready;

    // Scoreboard state
    logic [`MB_DATA_W-1:0] exp_q [$];
    frame_cmd_t            cur;
    int cur_frame, cur_total, err_idx, cycles;
    int aw_cnt, beat_cnt, b_issued, b_cnt, done_cnt;
    int data_err, frame_err, addr_err, done_err, resp_err_cnt;

    mb_writer dut0 (
        .clk, .rst_n, .start, .cmd, .enc_push, .enc_data, .enc_full,
        .busy, .done, .resp_err, .aw, .aw_valid, .aw_ready,
        .w, .w_valid, .w_ready, .b_resp, .b_valid, .b_ready
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run stopped after %0d cycles without finishing", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Bursts with both address and all data accepted
    function automatic int bursts_done();
        int full_bursts;
        full_bursts = beat_cnt / `MB_BEATS;
        return (aw_cnt < full_bursts) ? aw_cnt : full_bursts;
    endfunction

    // ------------------------------
    // AXI slave, driven on falling edges
    always @(negedge clk) begin
        if (rst_n) begin
            aw_ready = ($urandom % 4) != 0;
            w_ready  = ($urandom % 4) != 0;
            b_valid  = 1'b0;
            if (b_issued < bursts_done() && ($urandom % 3) == 0) begin
                b_valid = 1'b1;
                b_resp  = (cur_frame == 3 && b_issued == err_idx) ? SLVERR : OKAY;
                b_issued++;
            end
        end
    end

    // ------------------------------
    // Transfer monitor
    always @(posedge clk) begin : monitor
        logic [`MB_DATA_W-1:0] exp_word;
        logic [`MB_ADDR_W-1:0] exp_addr;
        if (rst_n) begin
            if (aw_valid && aw_ready) begin
                exp_addr = cur.base_addr + aw_cnt * `MB_BEATS * BYTES;
                assert (aw.addr == exp_addr && aw.len == 8'd6) else begin
                    addr_err++;
                    $display("** Error @ %0t ns: AW %0d addr %h len %0d, expected %h len 6",
                             $time, aw_cnt, aw.addr, aw.len, exp_addr);
                end
                aw_cnt++;
            end
            if (w_valid && w_ready) begin
                assert (exp_q.size() > 0) else begin
                    data_err++;
                    $display("** Error @ %0t ns: W beat %0d with no word pushed",
                             $time, beat_cnt);
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    assert (w.data == exp_word) else begin
                        data_err++;
                        $display("** Error @ %0t ns: W beat %0d data %h, expected %h",
                                 $time, beat_cnt, w.data, exp_word);
                    end
                end
                assert (w.last == ((beat_cnt % `MB_BEATS) == (`MB_BEATS - 1)) &&
                        w.strb == '1) else begin
                    frame_err++;
                    $display("** Error @ %0t ns: W beat %0d last %b strb %h",
                             $time, beat_cnt, w.last, w.strb);
                end
                beat_cnt++;
            end
            if (b_valid && b_ready) b_cnt++;
            if (done) begin
                done_cnt++;
                assert (b_cnt == cur_total) else begin
                    done_err++;
                    $display("** Error @ %0t ns: done after %0d of %0d responses",
                             $time, b_cnt, cur_total);
                end
            end
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            done_err++;
            $display("** Error @ %0t ns: done high for more than one cycle", $time);
        end

    idle_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else begin
            done_err++;
            $display("** Error @ %0t ns: busy still high with done", $time);
        end

    // ------------------------------
    // Encoder side with random gaps, never pushing while full
    task automatic push_words(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            enc_push = 1'b0;
            // Queue holds exactly the words still in the FIFO here
            assert (enc_full == (exp_q.size() >= FIFO_DEPTH)) else begin
                data_err++;
                $display("** Error @ %0t ns: enc_full %b with %0d words queued",
                         $time, enc_full, exp_q.size());
            end
            if (!enc_full && ($urandom % 3) != 0) begin
                enc_data = {$urandom, $urandom};
                enc_push = 1'b1;
                exp_q.push_back(enc_data);
                sent++;
            end
        end
        @(negedge clk);
        enc_push = 1'b0;
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!done);
    endtask

    task automatic run_frame(input logic [`MB_DIM_W-1:0] mb_w,
                             input logic [`MB_DIM_W-1:0] mb_h,
                             input logic [`MB_ADDR_W-1:0] base);
        int total;
        total = mb_w * mb_h;
        @(negedge clk);
        cur.mb_w      = mb_w;
        cur.mb_h      = mb_h;
        cur.base_addr = base;
        cur_total     = total;
        cur_frame++;
        aw_cnt   = 0;
        beat_cnt = 0;
        b_issued = 0;
        b_cnt    = 0;
        err_idx  = (total > 0) ? ($urandom % total) : 0;
        cmd   = cur;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        fork
            push_words(total * `MB_BEATS);
            wait_done();
        join
        // Monitor counts the done pulse on the next rising edge
        @(negedge clk);
        assert (beat_cnt == total * `MB_BEATS && aw_cnt == total) else begin
            frame_err++;
            $display("** Error @ %0t ns: frame %0d: %0d beats, %0d AW, expected %0d and %0d",
                     $time, cur_frame, beat_cnt, aw_cnt, total * `MB_BEATS, total);
        end
        assert (done_cnt == cur_frame && !busy) else begin
            done_err++;
            $display("** Error @ %0t ns: frame %0d done count %0d busy %b",
                     $time, cur_frame, done_cnt, busy);
        end
        assert (resp_err == (cur_frame == 3)) else begin
            resp_err_cnt++;
            $display("** Error @ %0t ns: frame %0d resp_err %b", $time, cur_frame, resp_err);
        end
    endtask

    initial begin
        void'($urandom(32'hf211));
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = '0;
        enc_push = 1'b0;
        enc_data = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_resp   = OKAY;
        b_valid  = 1'b0;
        cur      = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        run_frame(11'd1, 11'd1, 32'h1000_0000);
        run_frame(11'd3, 11'd2, 32'h1000_4000);
        run_frame(11'd4, 11'd3, 32'h2000_0000);
        run_frame(11'd0, 11'd5, 32'h3000_0000);

        $display("Errors: data %0d, framing %0d, address %0d, completion %0d, response %0d",
                 data_err, frame_err, addr_err, done_err, resp_err_cnt);
        if (data_err + frame_err + addr_err + done_err + resp_err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/mb_writer_chk.sv ====
/* AXI handshake checks bound into mb_writer. Payload stability is
   only checked while valid is high and ready is low. */
`timescale 1ns/1ns
`default_nettype none

module mb_writer_chk (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire mb_axi_pkg::axi_aw_t aw,
    input wire logic                aw_valid,
    input wire logic                aw_ready,
    input wire mb_axi_pkg::axi_w_t  w,
    input wire logic                w_valid,
    input wire logic                w_ready,
    input wire logic                b_ready,
    input wire logic                busy,
    input wire logic                done
);
    // ------------------------------
    // Valid and payload held until the transfer
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)))
        else $error("AW request dropped or changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (w_valid && !w_ready) |=> (w_valid && $stable(w)))
        else $error("W beat dropped or changed before w_ready");

    // B is always accepted
    b_always_ready: assert property (@(posedge clk) disable iff (!rst_n) b_ready)
        else $error("b_ready went low");

    // Outputs quiet while in reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!busy && !done && !aw_valid && !w_valid))
        else $error("Control or valid output high during reset");

endmodule

bind mb_writer mb_writer_chk chk0 (
    .clk, .rst_n, .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
    .b_ready, .busy, .done
);

`default_nettype wire

// ==== source/mb_writer.sv ====
/* Macroblock write-back top. Only the AXI4 write channels exist, and
   one frame runs at a time. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_writer (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start,
    input  wire mb_ctrl_pkg::frame_cmd_t cmd,
    input  wire logic                    enc_push,
    input  wire logic [`MB_DATA_W-1:0]   enc_data,
    output logic                         enc_full,
    output logic                         busy,
    output logic                         done,
    output logic                         resp_err,
    output mb_axi_pkg::axi_aw_t          aw,
    output logic                         aw_valid,
    input  wire logic                    aw_ready,
    output mb_axi_pkg::axi_w_t           w,
    output logic                         w_valid,
    input  wire logic                    w_ready,
    input  wire mb_axi_pkg::axi_resp_e   b_resp,
    input  wire logic                    b_valid,
    output logic                         b_ready
);
    logic                   mb_go;
    logic                   frame_start;
    logic [2*`MB_DIM_W-1:0] mb_total;
    logic [`MB_ADDR_W-1:0]  base_addr;
    logic                   aw_done;
    logic                   w_done;
    logic                   all_acked;
    logic                   fifo_empty;
    logic                   fifo_pop;
    logic [`MB_DATA_W-1:0]  fifo_data;

    // ------------------------------
    // Control
    mb_frame_ctrl u_ctrl (
        .clk, .rst_n, .start, .cmd, .aw_done, .w_done, .all_acked,
        .mb_go, .frame_start, .mb_total, .base_addr, .busy, .done
    );

    // ------------------------------
    // Datapath
    mb_stage_fifo #(.DEPTH(16)) u_fifo (
        .clk, .rst_n,
        .push(enc_push), .push_data(enc_data), .pop(fifo_pop),
        .full(enc_full), .empty(fifo_empty), .pop_data(fifo_data)
    );

    mb_aw_gen u_aw (
        .clk, .rst_n, .frame_start, .mb_go, .base_addr, .aw_ready,
        .aw, .aw_valid, .aw_done
    );

    mb_wdata_chan u_wdata (
        .clk, .rst_n, .mb_go, .fifo_empty, .fifo_data, .w_ready,
        .w, .w_valid, .fifo_pop, .w_done
    );

    mb_bresp_track u_bresp (
        .clk, .rst_n, .frame_start, .mb_total, .b_resp, .b_valid,
        .b_ready, .all_acked, .resp_err
    );

endmodule

`default_nettype wire

// ==== source/mb_bresp_track.sv ====
/* Write response counter. B is always accepted, and the error flag
   holds until the next frame starts. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_bresp_track (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      frame_start,
    input  wire logic [2*`MB_DIM_W-1:0]    mb_total,
    input  wire mb_axi_pkg::axi_resp_e     b_resp,
    input  wire logic                      b_valid,
    output logic                           b_ready,
    output logic                           all_acked,
    output logic                           resp_err
);
    import mb_axi_pkg::*;

    logic [2*`MB_DIM_W-1:0] resp_cnt;
    logic                   accept;

    assign b_ready = 1'b1;
    assign accept  = b_valid & b_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_cnt  <= '0;
            all_acked <= 1'b0;
            resp_err  <= 1'b0;
        end else begin
            all_acked <= accept && (resp_cnt + 1'b1 == mb_total);
            if (frame_start) begin
                resp_cnt <= '0;
                resp_err <= 1'b0;
            end else if (accept) begin
                resp_cnt <= resp_cnt + 1'b1;
                if (b_resp == SLVERR || b_resp == DECERR) resp_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mb_wdata_chan.sv ====
/* W channel streamer. Beats are presented straight from the FIFO head
   and only full-width writes are made, so the strobe is all ones. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_wdata_chan (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  mb_go,
    input  wire logic                  fifo_empty,
    input  wire logic [`MB_DATA_W-1:0] fifo_data,
    input  wire logic                  w_ready,
    output mb_axi_pkg::axi_w_t         w,
    output logic                       w_valid,
    output logic                       fifo_pop,
    output logic                       w_done
);
    import mb_axi_pkg::*;

    localparam logic [2:0] LAST_BEAT = 3'(`MB_BEATS - 1);

    logic       active;
    logic [2:0] beat_cnt;
    logic       xfer;

    // Valid never waits on ready
    assign w_valid  = active & ~fifo_empty;
    assign xfer     = w_valid & w_ready;
    assign fifo_pop = xfer;
    assign w_done   = xfer & w.last;

    assign w.data = fifo_data;
    assign w.strb = '1;
    assign w.last = (beat_cnt == LAST_BEAT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (mb_go) begin
                active   <= 1'b1;
                beat_cnt <= '0;
            end else if (xfer) begin
                if (w.last) begin
                    active   <= 1'b0;
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mb_aw_gen.sv ====
/* One incrementing burst request per macroblock. Bursts sit back to
   back in memory, so the base address should be burst aligned. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_aw_gen (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  frame_start,
    input  wire logic                  mb_go,
    input  wire logic [`MB_ADDR_W-1:0] base_addr,
    input  wire logic                  aw_ready,
    output mb_axi_pkg::axi_aw_t        aw,
    output logic                       aw_valid,
    output logic                       aw_done
);
    import mb_axi_pkg::*;

    // Bytes covered by one macroblock burst
    localparam logic [`MB_ADDR_W-1:0] MB_STEP   = `MB_BEATS * (`MB_DATA_W / 8);
    localparam logic [7:0]            BURST_LEN = `MB_BEATS - 1;

    logic [`MB_ADDR_W-1:0] addr_q;

    assign aw_done  = aw_valid & aw_ready;
    assign aw.addr  = addr_q;
    assign aw.len   = BURST_LEN;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q   <= '0;
            aw_valid <= 1'b0;
        end else begin
            if (frame_start) begin
                addr_q <= base_addr;
            end else if (aw_done) begin
                addr_q <= addr_q + MB_STEP;
            end
            // Held until the slave takes it
            if (mb_go) begin
                aw_valid <= 1'b1;
            end else if (aw_done) begin
                aw_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mb_stage_fifo.sv ====
/* Staging FIFO with first-word-fall-through read. DEPTH must be a
   power of two; a push while full or a pop while empty is dropped. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_stage_fifo #(
    parameter int DEPTH = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  push,
    input  wire logic [`MB_DATA_W-1:0] push_data,
    input  wire logic                  pop,
    output logic                       full,
    output logic                       empty,
    output logic [`MB_DATA_W-1:0]      pop_data
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [`MB_DATA_W-1:0] mem [DEPTH];
    // Extra top bit tells full from empty
    logic [PTR_W:0]        wr_ptr;
    logic [PTR_W:0]        rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_data = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr[PTR_W-1:0]] <= push_data;
    end

endmodule

`default_nettype wire

// ==== source/mb_frame_ctrl.sv ====
/* Frame sequencer. A start outside IDLE is ignored, and a frame with
   a zero dimension completes without any bus traffic. */
`timescale 1ns/1ns
`default_nettype none

`include "mb_writer_params.svh"

module mb_frame_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start,
    input  wire mb_ctrl_pkg::frame_cmd_t   cmd,
    input  wire logic                      aw_done,
    input  wire logic                      w_done,
    input  wire logic                      all_acked,
    output logic                           mb_go,
    output logic                           frame_start,
    output logic [2*`MB_DIM_W-1:0]         mb_total,
    output logic [`MB_ADDR_W-1:0]          base_addr,
    output logic                           busy,
    output logic                           done
);
    import mb_ctrl_pkg::*;

    ctrl_state_e            state;
    ctrl_state_e            state_nxt;
    frame_cmd_t             cmd_q;
    logic [2*`MB_DIM_W-1:0] mb_cnt;
    logic                   aw_seen;
    logic                   w_seen;
    logic                   mb_fin;
    logic                   last_mb;
    logic                   zero_frame;

    // Both halves of the current macroblock are through
    assign mb_fin     = (aw_seen | aw_done) & (w_seen | w_done);
    assign last_mb    = (mb_cnt + 1'b1 == mb_total);
    assign zero_frame = (cmd_q.mb_w == '0) || (cmd_q.mb_h == '0);

    assign frame_start = (state == INIT);
    assign base_addr   = cmd_q.base_addr;
    assign busy        = (state != IDLE);

    // ------------------------------
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (start) state_nxt = INIT;
            INIT: state_nxt = zero_frame ? DONE : WAIT;
            WAIT: state_nxt = SEND;
            SEND: if (mb_fin) state_nxt = last_mb ? DONE : WAIT;
            DONE: if (all_acked || mb_total == '0) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            mb_total <= '0;
            mb_cnt   <= '0;
            aw_seen  <= 1'b0;
            w_seen   <= 1'b0;
            mb_go    <= 1'b0;
            done     <= 1'b0;
        end else begin
            state <= state_nxt;
            // Pulse lands in the first SEND cycle
            mb_go <= (state == WAIT);
            done  <= (state == DONE) && (state_nxt == IDLE);
            if (state == INIT) begin
                mb_total <= cmd_q.mb_w * cmd_q.mb_h;
                mb_cnt   <= '0;
            end
            if (state == SEND && mb_fin) begin
                mb_cnt  <= mb_cnt + 1'b1;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end else begin
                if (aw_done) aw_seen <= 1'b1;
                if (w_done) w_seen <= 1'b1;
            end
        end
    end

    // Command payload held for the whole frame
    always_ff @(posedge clk) begin
        if (state == IDLE && start) cmd_q <= cmd;
    end

endmodule

`default_nettype wire

// ==== source/mb_ctrl_pkg.sv ====
/* Frame command and controller state types. Frames are limited to
   2047 by 2047 macroblocks by the dimension width. */
`default_nettype none

`include "mb_writer_params.svh"

package mb_ctrl_pkg;

    typedef struct packed {
        logic [`MB_DIM_W-1:0]  mb_w;
        logic [`MB_DIM_W-1:0]  mb_h;
        logic [`MB_ADDR_W-1:0] base_addr;
    } frame_cmd_t;

    typedef enum logic [2:0] {IDLE, INIT, WAIT, SEND, DONE} ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/mb_axi_pkg.sv ====
/* AXI4 write-side payload types. No IDs, no read channels, and every
   burst is incrementing and full width. */
`default_nettype none

`include "mb_writer_params.svh"

package mb_axi_pkg;

    // Write address request
    typedef struct packed {
        logic [`MB_ADDR_W-1:0] addr;
        logic [7:0]            len;
    } axi_aw_t;

    // One write data beat
    typedef struct packed {
        logic [`MB_DATA_W-1:0]   data;
        logic [`MB_DATA_W/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    // BRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

// ==== include/mb_writer_params.svh ====
/* Build-wide sizes for the macroblock writer. The data width must be a
   multiple of 8, and MB_BEATS must fit the three-bit beat counter. */
`ifndef MB_WRITER_PARAMS_SVH
`define MB_WRITER_PARAMS_SVH

// Encoder word and W beat width, 1024 in silicon
`define MB_DATA_W 64

// AXI byte address width
`define MB_ADDR_W 32

// Beats per macroblock burst, AWLEN is one less
`define MB_BEATS 7

// Width of each frame dimension in macroblocks
`define MB_DIM_W 11

`endif
